// ==== src/tm1638_pkg.sv ====
/*
 * TM1638 board constants, command bytes and shared types
 */
`default_nettype none

package tm1638_pkg;

    typedef logic [6:0] seg_t;     // segments a..g, a in bit 0
    typedef logic [7:0] tm_byte_t;
    typedef logic [7:0] keys_t;

    localparam int unsigned num_digits = 8;
    localparam int unsigned num_reads  = 4;   // key bytes per frame

    // command bytes
    localparam tm_byte_t cmd_write_auto = 8'h40;
    localparam tm_byte_t cmd_disp_addr  = 8'hC0;   // address 0
    localparam tm_byte_t cmd_disp_on    = 8'h8F;   // full brightness
    localparam tm_byte_t cmd_key_read   = 8'h42;

endpackage

`default_nettype wire

// ==== src/tm_byte_if.sv ====
/*
 * byte transfer request and completion, sequencer to serial engine
 */
`timescale 1ns/10ps
`default_nettype none

interface tm_byte_if;

    logic                  start;
    tm1638_pkg::tm_byte_t  tx_byte;
    logic                  is_read;
    logic                  last_in_group;  // strobe released after this byte
    logic                  done;

    modport seq (
        output start, tx_byte, is_read, last_in_group,
        input  done
    );

    modport eng (
        input  start, tx_byte, is_read, last_in_group,
        output done
    );

endinterface

`default_nettype wire

// ==== src/tm1638_frame_seq.sv ====
/*
 * frame timer and per-frame byte sequencer
 * display byte selection from latched segment, dot and LED inputs
 */
`timescale 1ns/10ps
`default_nettype none

module tm1638_frame_seq #(
    parameter int unsigned clk_freq_hz = 48_000_000,
    parameter int unsigned fps         = 250
) (
    input  wire                                             clk,
    input  wire                                             n_rst,
    input  wire tm1638_pkg::seg_t [tm1638_pkg::num_digits-1:0] seg_i,
    input  wire [7:0]                                       dots_i,
    input  wire [7:0]                                       leds_i,
    output logic                                            frame_req_o,
    tm_byte_if.seq                                          bus
);

    localparam int unsigned frame_len = clk_freq_hz / fps;
    localparam int unsigned cnt_w     = (frame_len > 1) ? $clog2(frame_len) : 1;
    localparam logic [4:0]  last_step = 5'd23;

    logic [cnt_w-1:0] tick_cnt;
    logic             frame_tick;
    logic             busy;
    logic [4:0]       step;
    logic [4:0]       disp_idx;

    tm1638_pkg::seg_t [tm1638_pkg::num_digits-1:0] seg_q;
    logic [7:0] dots_q;
    logic [7:0] leds_q;

    assign frame_tick = (tick_cnt == cnt_w'(frame_len - 1));
    assign disp_idx   = step - 5'd2;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            tick_cnt <= '0;
        end else if (frame_tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // ticks during a running frame are dropped
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            frame_req_o <= 1'b0;
            busy        <= 1'b0;
            step        <= '0;
            bus.start   <= 1'b0;
        end else begin
            frame_req_o <= 1'b0;
            bus.start   <= 1'b0;
            if (frame_tick && !busy) begin
                frame_req_o <= 1'b1;
                busy        <= 1'b1;
                step        <= '0;
                bus.start   <= 1'b1;
            end else if (busy && bus.done) begin
                if (step == last_step) begin
                    busy <= 1'b0;
                end else begin
                    step      <= step + 5'd1;
                    bus.start <= 1'b1;
                end
            end
        end
    end

    // display inputs held in the frame_req_o cycle
    always_ff @(posedge clk) begin
        if (frame_req_o) begin
            seg_q  <= seg_i;
            dots_q <= dots_i;
            leds_q <= leds_i;
        end
    end

    always_comb begin
        bus.tx_byte       = tm1638_pkg::cmd_write_auto;
        bus.is_read       = 1'b0;
        bus.last_in_group = 1'b0;
        if (step == 5'd0) begin
            bus.last_in_group = 1'b1;
        end else if (step == 5'd1) begin
            bus.tx_byte = tm1638_pkg::cmd_disp_addr;
        end else if (step <= 5'd17) begin
            if (disp_idx[0]) begin
                bus.tx_byte = {7'b0, leds_q[disp_idx[3:1]]};
            end else begin
                bus.tx_byte = {dots_q[disp_idx[3:1]], seg_q[disp_idx[3:1]]};
            end
            bus.last_in_group = (step == 5'd17);
        end else if (step == 5'd18) begin
            bus.tx_byte       = tm1638_pkg::cmd_disp_on;
            bus.last_in_group = 1'b1;
        end else if (step == 5'd19) begin
            bus.tx_byte = tm1638_pkg::cmd_key_read;
        end else begin
            bus.tx_byte       = 8'hFF;   // line released during reads
            bus.is_read       = 1'b1;
            bus.last_in_group = (step == last_step);
        end
    end

endmodule

`default_nettype wire

// ==== src/tm1638_serial_engine.sv ====
/*
 * serial byte engine with half-period divider and bit shifter
 * drives clock, strobe and data and samples reads on rising clock
 */
`timescale 1ns/10ps
`default_nettype none

module tm1638_serial_engine #(
    parameter int unsigned clk_freq_hz  = 48_000_000,
    parameter int unsigned sclk_freq_hz = 1_000_000
) (
    input  wire                   clk,
    input  wire                   n_rst,
    tm_byte_if.eng                bus,
    input  wire                   data_i,
    output logic                  tm1638_clk_o,
    output logic                  tm1638_stb_o,
    output logic                  tm1638_data_o,
    output logic                  tm1638_oe_o,
    output logic                  rx_valid_o,
    output tm1638_pkg::tm_byte_t  rx_byte_o
);

    // rounded up
    localparam int unsigned half_div =
        (clk_freq_hz + 2 * sclk_freq_hz - 1) / (2 * sclk_freq_hz);
    localparam int unsigned div_w = (half_div > 1) ? $clog2(half_div) : 1;

    typedef enum logic [2:0] {st_idle, st_stb, st_low, st_high, st_rel} state_t;

    state_t               state;
    logic [div_w-1:0]     div_cnt;
    logic                 half_tick;
    logic [2:0]           bit_cnt;
    logic                 is_read_q;
    logic                 last_q;
    tm1638_pkg::tm_byte_t shift_q;

    assign half_tick = (state != st_idle) && (div_cnt == div_w'(half_div - 1));
    assign rx_byte_o = shift_q;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            div_cnt <= '0;
        end else if (state == st_idle || half_tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && bus.start) begin
            shift_q <= bus.tx_byte;
        end else if (state == st_low && half_tick) begin
            shift_q <= {is_read_q & data_i, shift_q[7:1]};  // LSB first
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state         <= st_idle;
            tm1638_clk_o  <= 1'b1;
            tm1638_stb_o  <= 1'b1;
            tm1638_data_o <= 1'b1;
            tm1638_oe_o   <= 1'b0;
            bus.done      <= 1'b0;
            rx_valid_o    <= 1'b0;
            bit_cnt       <= '0;
            is_read_q     <= 1'b0;
            last_q        <= 1'b0;
        end else begin
            bus.done   <= 1'b0;
            rx_valid_o <= 1'b0;
            case (state)
                st_idle: begin
                    if (bus.start) begin
                        is_read_q   <= bus.is_read;
                        last_q      <= bus.last_in_group;
                        bit_cnt     <= '0;
                        tm1638_oe_o <= ~bus.is_read;
                        if (bus.is_read) begin
                            tm1638_data_o <= 1'b1;
                        end
                        if (tm1638_stb_o) begin  // new group needs strobe setup first
                            tm1638_stb_o <= 1'b0;
                            state        <= st_stb;
                        end else begin
                            tm1638_clk_o <= 1'b0;
                            state        <= st_low;
                        end
                    end
                end
                st_stb: begin
                    if (half_tick) begin
                        tm1638_clk_o <= 1'b0;
                        state        <= st_low;
                    end
                end
                st_low: begin
                    if (div_cnt == '0 && !is_read_q) begin
                        tm1638_data_o <= shift_q[0];
                    end
                    if (half_tick) begin
                        tm1638_clk_o <= 1'b1;
                        rx_valid_o   <= is_read_q && (bit_cnt == 3'd7);
                        state        <= st_high;
                    end
                end
                st_high: begin
                    if (half_tick) begin
                        if (bit_cnt != 3'd7) begin
                            bit_cnt      <= bit_cnt + 3'd1;
                            tm1638_clk_o <= 1'b0;
                            state        <= st_low;
                        end else if (last_q) begin
                            tm1638_stb_o  <= 1'b1;
                            tm1638_data_o <= 1'b1;
                            state         <= st_rel;
                        end else begin
                            bus.done <= 1'b1;
                            state    <= st_idle;
                        end
                    end
                end
                st_rel: begin
                    if (half_tick) begin  // strobe high gap before next group
                        bus.done <= 1'b1;
                        state    <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/tm1638_key_capture.sv ====
/*
 * key capture from the four read bytes of a frame
 */
`timescale 1ns/10ps
`default_nettype none

module tm1638_key_capture (
    input  wire                        clk,
    input  wire                        n_rst,
    input  wire                        rx_valid_i,
    input  wire tm1638_pkg::tm_byte_t  rx_byte_i,
    output tm1638_pkg::keys_t          keys_o
);

    logic [1:0]        rd_cnt;
    logic [2:0]        hi_idx;
    tm1638_pkg::keys_t stage_q;
    tm1638_pkg::keys_t stage_nxt;

    // byte j carries keys 7-2j and 6-2j
    assign hi_idx = 3'd7 - {rd_cnt, 1'b0};

    always_comb begin
        stage_nxt                  = stage_q;
        stage_nxt[hi_idx]          = rx_byte_i[0];
        stage_nxt[hi_idx - 3'd1]   = rx_byte_i[4];
    end

    always_ff @(posedge clk) begin
        if (rx_valid_i) begin
            stage_q <= stage_nxt;
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            rd_cnt <= '0;
            keys_o <= '0;
        end else if (rx_valid_i) begin
            rd_cnt <= rd_cnt + 2'd1;  // wraps each frame
            if (rd_cnt == 2'(tm1638_pkg::num_reads - 1)) begin
                keys_o <= stage_nxt;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/tm1638_drv.sv ====
/*
 * TM1638 LED and key board driver, top level
 */
`timescale 1ns/10ps
`default_nettype none

module tm1638_drv #(
    parameter int unsigned clk_freq_hz  = 48_000_000,
    parameter int unsigned sclk_freq_hz = 1_000_000,
    parameter int unsigned fps          = 250
) (
    input  wire                    clk,
    input  wire                    n_rst,
    input  wire tm1638_pkg::seg_t  seg0_i,
    input  wire tm1638_pkg::seg_t  seg1_i,
    input  wire tm1638_pkg::seg_t  seg2_i,
    input  wire tm1638_pkg::seg_t  seg3_i,
    input  wire tm1638_pkg::seg_t  seg4_i,
    input  wire tm1638_pkg::seg_t  seg5_i,
    input  wire tm1638_pkg::seg_t  seg6_i,
    input  wire tm1638_pkg::seg_t  seg7_i,
    input  wire [7:0]              dots_i,
    input  wire [7:0]              leds_i,
    input  wire                    data_i,
    output logic                   frame_req_o,
    output logic                   tm1638_clk_o,
    output logic                   tm1638_stb_o,
    output logic                   tm1638_data_o,
    output logic                   tm1638_oe_o,
    output tm1638_pkg::keys_t      keys_o
);

    tm_byte_if byte_bus ();

    logic                 rx_valid;
    tm1638_pkg::tm_byte_t rx_byte;

    tm1638_frame_seq #(
        .clk_freq_hz (clk_freq_hz),
        .fps         (fps)
    ) i_frame_seq (
        .clk         (clk),
        .n_rst       (n_rst),
        .seg_i       ({seg7_i, seg6_i, seg5_i, seg4_i, seg3_i, seg2_i, seg1_i, seg0_i}),
        .dots_i      (dots_i),
        .leds_i      (leds_i),
        .frame_req_o (frame_req_o),
        .bus         (byte_bus)
    );

    tm1638_serial_engine #(
        .clk_freq_hz  (clk_freq_hz),
        .sclk_freq_hz (sclk_freq_hz)
    ) i_serial_engine (
        .clk           (clk),
        .n_rst         (n_rst),
        .bus           (byte_bus),
        .data_i        (data_i),
        .tm1638_clk_o  (tm1638_clk_o),
        .tm1638_stb_o  (tm1638_stb_o),
        .tm1638_data_o (tm1638_data_o),
        .tm1638_oe_o   (tm1638_oe_o),
        .rx_valid_o    (rx_valid),
        .rx_byte_o     (rx_byte)
    );

    tm1638_key_capture i_key_capture (
        .clk        (clk),
        .n_rst      (n_rst),
        .rx_valid_i (rx_valid),
        .rx_byte_i  (rx_byte),
        .keys_o     (keys_o)
    );

endmodule

`default_nettype wire

// ==== dv/tb_tm1638_drv.sv ====
/*
 * testbench for the TM1638 driver with clock, reset, board model,
 * watchdog, compare tasks and directed tests
 */
`timescale 1ns/10ps
`default_nettype none

module tb_tm1638_drv;

    localparam int unsigned clk_hz      = 240_000;
    localparam int unsigned sclk_hz     = 30_000;  // 4 clk per half period
    localparam int unsigned fps_val     = 100;
    localparam int          frame_len   = clk_hz / fps_val;
    localparam int          num_tests   = 7;
    localparam int          watchdog_ns = (num_tests * 2 * frame_len + 1000) * 8;

    logic                 clk;
    logic                 n_rst;
    tm1638_pkg::seg_t     seg_in [8];
    logic [7:0]           dots_in;
    logic [7:0]           leds_in;
    logic                 data_i;
    logic                 frame_req_o;
    logic                 tm1638_clk_o;
    logic                 tm1638_stb_o;
    logic                 tm1638_data_o;
    logic                 tm1638_oe_o;
    tm1638_pkg::keys_t    keys_o;

    // board model state
    tm1638_pkg::keys_t    board_keys;
    tm1638_pkg::tm_byte_t shift_in;
    tm1638_pkg::tm_byte_t grp_first [4];
    int                   grp_len [4];
    tm1638_pkg::tm_byte_t disp_q [$];
    int                   grp_idx;
    int                   byte_idx;
    int                   bit_idx;
    logic                 sclk_q;
    logic                 stb_q;
    logic                 frame_done;

    int                   cyc;
    int                   prev_req_cyc;
    int                   last_req_cyc;
    logic [31:0]          rng_state;

    tm1638_drv #(
        .clk_freq_hz  (clk_hz),
        .sclk_freq_hz (sclk_hz),
        .fps          (fps_val)
    ) i_dut (
        .clk           (clk),
        .n_rst         (n_rst),
        .seg0_i        (seg_in[0]),
        .seg1_i        (seg_in[1]),
        .seg2_i        (seg_in[2]),
        .seg3_i        (seg_in[3]),
        .seg4_i        (seg_in[4]),
        .seg5_i        (seg_in[5]),
        .seg6_i        (seg_in[6]),
        .seg7_i        (seg_in[7]),
        .dots_i        (dots_in),
        .leds_i        (leds_in),
        .data_i        (data_i),
        .frame_req_o   (frame_req_o),
        .tm1638_clk_o  (tm1638_clk_o),
        .tm1638_stb_o  (tm1638_stb_o),
        .tm1638_data_o (tm1638_data_o),
        .tm1638_oe_o   (tm1638_oe_o),
        .keys_o        (keys_o)
    );

    always #4 clk = ~clk;

    initial begin
        #(watchdog_ns);
        $display("watchdog expired at %0t, the run did not finish", $time);
        $display("Result: FAILED");
        $fatal(1, "watchdog");
    end

    task automatic report_fail(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t waiting for %s", $time, what);
        $display("Result: FAILED");
        $fatal(1, "timeout");
    endtask

    task automatic check_byte(input tm1638_pkg::tm_byte_t got, input tm1638_pkg::tm_byte_t exp,
                              input string what);
        if (got !== exp) report_fail($sformatf("%s: got %02h, expected %02h", what, got, exp));
    endtask

    task automatic check_keys(input tm1638_pkg::keys_t got, input tm1638_pkg::keys_t exp,
                              input string what);
        if (got !== exp) report_fail($sformatf("%s: got %08b, expected %08b", what, got, exp));
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) report_fail($sformatf("%s: got %b, expected %b", what, got, exp));
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) report_fail($sformatf("%s: got %0d, expected %0d", what, got, exp));
    endtask

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // keys 7-2rd and 6-2rd ride in bits 0 and 4 of read byte rd
    function automatic logic key_bit(input tm1638_pkg::keys_t keys, input int rd, input int b);
        if (b == 0) return keys[7 - 2 * rd];
        if (b == 4) return keys[6 - 2 * rd];
        return 1'b0;
    endfunction

    // board model sees DUT outputs one clk late
    always @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            sclk_q     = 1'b1;
            stb_q      = 1'b1;
            grp_idx    = 0;
            byte_idx   = 0;
            bit_idx    = 0;
            frame_done = 1'b0;
            data_i    <= 1'b1;
        end else begin
            if (frame_req_o) begin
                if (grp_idx != 0 && grp_idx != 4) report_fail("wrong number of strobe groups");
                grp_idx    = 0;
                frame_done = 1'b0;
                disp_q.delete();
            end
            if (stb_q && !tm1638_stb_o) begin  // group start
                byte_idx = 0;
                bit_idx  = 0;
            end
            if (!sclk_q && tm1638_clk_o && !tm1638_stb_o) begin
                check_bit(tm1638_oe_o, (grp_idx == 3 && byte_idx > 0) ? 1'b0 : 1'b1,
                          "oe at rising clock");
                shift_in = {tm1638_data_o, shift_in[7:1]};  // LSB first
                bit_idx++;
                if (bit_idx == 8) begin
                    if (grp_idx < 4 && byte_idx == 0) grp_first[grp_idx] = shift_in;
                    if (grp_idx == 1 && byte_idx > 0) disp_q.push_back(shift_in);
                    byte_idx++;
                    bit_idx = 0;
                end
            end
            if (!stb_q && tm1638_stb_o) begin  // group end
                if (grp_idx < 4) grp_len[grp_idx] = byte_idx;
                grp_idx++;
                frame_done = (grp_idx == 4);
            end
            sclk_q = tm1638_clk_o;
            stb_q  = tm1638_stb_o;
            if (!tm1638_oe_o && grp_idx == 3 && byte_idx > 0 && byte_idx <= 4) begin
                data_i <= key_bit(board_keys, byte_idx - 1, bit_idx);
            end else begin
                data_i <= 1'b1;  // pull-up
            end
        end
    end

    // frame request spacing
    always @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            cyc          <= 0;
            prev_req_cyc <= 0;
            last_req_cyc <= 0;
        end else begin
            cyc <= cyc + 1;
            if (frame_req_o) begin
                prev_req_cyc <= last_req_cyc;
                last_req_cyc <= cyc;
            end
        end
    end

    task automatic wait_frame_req();
        int n;
        n = 0;
        @(negedge clk);
        while (!frame_req_o) begin
            n++;
            if (n > 2 * frame_len) report_timeout("frame request");
            @(negedge clk);
        end
    endtask

    task automatic wait_frame_done();
        int n;
        n = 0;
        @(negedge clk);
        while (!frame_done) begin
            n++;
            if (n > frame_len) report_timeout("end of group 4");
            @(negedge clk);
        end
    endtask

    // random segment and dot and LED inputs on the current clock edge
    task automatic drive_random_display();
        logic [31:0] r;
        int          k;
        for (k = 0; k < 8; k++) begin
            r = next_random();
            seg_in[k] <= r[6:0];
        end
        r = next_random();
        dots_in <= r[7:0];
        leds_in <= r[15:8];
    endtask

    task automatic test_reset();
        int n;
        n = 0;
        @(negedge clk);
        while (!frame_req_o) begin
            check_bit(tm1638_clk_o, 1'b1, "clock after reset");
            check_bit(tm1638_stb_o, 1'b1, "strobe after reset");
            check_bit(tm1638_data_o, 1'b1, "data after reset");
            check_bit(tm1638_oe_o, 1'b0, "oe after reset");
            check_keys(keys_o, 8'h00, "keys after reset");
            n++;
            if (n > frame_len + 10) report_timeout("first frame request");
            @(negedge clk);
        end
    endtask

    // one frame with random display inputs and key word
    task test_frame();
        logic [31:0]          r;
        int                   k;
        tm1638_pkg::tm_byte_t exp_first [4];
        int                   exp_len [4];
        tm1638_pkg::seg_t     exp_seg [8];
        logic [7:0]           exp_dots;
        logic [7:0]           exp_leds;
        exp_first = '{8'h40, 8'hC0, 8'h8F, 8'h42};
        exp_len   = '{1, 17, 1, 5};
        @(posedge clk);
        drive_random_display();
        r = next_random();
        board_keys <= r[7:0];
        wait_frame_req();
        exp_seg  = seg_in;
        exp_dots = dots_in;
        exp_leds = leds_in;
        @(posedge clk);
        drive_random_display();  // too late for this frame
        wait_frame_done();
        for (k = 0; k < 4; k++) begin
            check_byte(grp_first[k], exp_first[k], $sformatf("first byte of group %0d", k + 1));
            check_count(grp_len[k], exp_len[k], $sformatf("length of group %0d", k + 1));
        end
        check_count(disp_q.size(), 16, "display bytes");
        for (k = 0; k < 8; k++) begin
            check_byte(disp_q[2 * k], {exp_dots[k], exp_seg[k]}, $sformatf("digit %0d", k));
            check_byte(disp_q[2 * k + 1], {7'b0, exp_leds[k]}, $sformatf("led %0d", k));
        end
        check_keys(keys_o, board_keys, "key word after group 4");
    endtask

    task automatic test_frame_rate();
        wait_frame_req();
        @(negedge clk);
        check_count(last_req_cyc - prev_req_cyc, frame_len, "cycles between frame requests");
    endtask

    initial begin
        clk        = 1'b0;
        n_rst      = 1'b0;
        data_i     = 1'b1;
        dots_in    = 8'h00;
        leds_in    = 8'h00;
        board_keys = 8'h00;
        rng_state  = 32'h7f8ef662;
        for (int k = 0; k < 8; k++) begin
            seg_in[k] = 7'h00;
        end
        repeat (10) @(posedge clk);
        n_rst <= 1'b1;
        test_reset();
        repeat (5) test_frame();
        test_frame_rate();
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
src/tm1638_pkg.sv
src/tm_byte_if.sv
src/tm1638_frame_seq.sv
src/tm1638_serial_engine.sv
src/tm1638_key_capture.sv
src/tm1638_drv.sv
dv/tb_tm1638_drv.sv

// ==== Bender.yml ====
package:
  name: tm1638_drv

sources:
  # package and interface before their users
  - src/tm1638_pkg.sv
  - src/tm_byte_if.sv
  - src/tm1638_frame_seq.sv
  - src/tm1638_serial_engine.sv
  - src/tm1638_key_capture.sv
  - src/tm1638_drv.sv

  - target: test
    files:
      - dv/tb_tm1638_drv.sv
